//--- mpu_consts.svh
// Timer unit constants

`ifndef MPU_CONSTS_SVH
`define MPU_CONSTS_SVH

// =========================================================================
// Channel count
// =========================================================================

// Number of interval timer channels in the slice
`define PIT_CHANNELS 4

// Width of the channel index carried with an access
`define PIT_CHAN_BITS 2

// =========================================================================
// Address map
// =========================================================================

// Region code sits in the top nibble of the address
`define REGION_LSB 28

// Region code that selects the configuration space
`define CFG_REGION 4'hD

// Channel field occupies address bits 6..5
`define CHAN_LSB 5

// Register field occupies address bits 4..3, one 64-bit word per register
`define REG_LSB 3

`endif

//--- fta_bus_pkg.sv
// Request and response bus types

package fta_bus_pkg;

// =========================================================================
// Bus payload
// =========================================================================

// Transaction tag, returned unchanged with the matching response
typedef logic [7:0] tid_t;

// One 64-bit data word as carried on both request and response sides
typedef logic [63:0] data_t;

// =========================================================================
// Response status
// =========================================================================

// OKAY for a normal completion
// DECERR when no slave claims the address
typedef enum logic [1:0]
{
	OKAY   = 2'd0,
	DECERR = 2'd3
} bus_err_e;

endpackage

//--- pit_pkg.sv
// Interval timer types

package pit_pkg;

// Count and reload values are 32 bits wide
typedef logic [31:0] pit_count_t;

// =========================================================================
// Register map and modes
// =========================================================================

// Register offset within one channel, taken from the address register field
typedef enum logic [1:0]
{
	REG_CTRL   = 2'd0,
	REG_RELOAD = 2'd1,
	REG_COUNT  = 2'd2,
	REG_STATUS = 2'd3
} pit_reg_e;

// Counting mode
// One-shot stops at zero with the output high, periodic reloads and toggles
typedef enum logic [1:0]
{
	MODE_ONESHOT  = 2'd0,
	MODE_PERIODIC = 2'd1
} pit_mode_e;

// =========================================================================
// Write word views
// =========================================================================

// Control word, enable in bit 0 and the interrupt enable in bit 3
typedef struct packed
{
	logic [59:0] rsvd;
	logic irq_en;
	pit_mode_e mode;
	logic enable;
} pit_ctrl_t;

// The same write word seen as a control word or as a reload value
// Only the low half carries the reload value
typedef union packed
{
	pit_ctrl_t ctrl;
	struct packed
	{
		logic [31:0] unused;
		pit_count_t value;
	} rld;
} pit_wdata_u;

endpackage

//--- pit_reg_decoder.sv
// Timer register decoder

`timescale 1ns/100ps
`include "mpu_consts.svh"

module pit_reg_decoder
(
	input  logic clk_i,
	input  logic reset_i,
	input  logic req_valid_i,
	output logic req_ready_o,
	input  logic req_we_i,
	input  logic [31:0] req_adr_i,
	input  fta_bus_pkg::data_t req_dat_i,
	input  fta_bus_pkg::tid_t req_tid_i,
	output logic [`PIT_CHANNELS-1:0] chan_sel_o,
	output logic reg_we_o,
	output pit_pkg::pit_reg_e reg_ofs_o,
	output pit_pkg::pit_wdata_u reg_wdata_o,
	output logic acc_valid_o,
	output logic [`PIT_CHAN_BITS-1:0] acc_chan_o,
	output fta_bus_pkg::tid_t acc_tid_o,
	output fta_bus_pkg::bus_err_e acc_err_o,
	input  logic acc_ready_i
);

import fta_bus_pkg::*;
import pit_pkg::*;

// Slot state, an access is first decoded and then issued
logic pend_q;
logic iss_q;
logic accept;
logic fire;

// Request payload, held from acceptance until the access issues
logic we_q;
logic [31:0] adr_q;
data_t dat_q;
tid_t tid_q;

// Decode results
logic hit;
logic [`PIT_CHAN_BITS-1:0] chan_d;
logic [`PIT_CHANNELS-1:0] sel_d;
logic [`PIT_CHANNELS-1:0] sel_q;
pit_reg_e ofs_q;
logic [`PIT_CHAN_BITS-1:0] chan_q;
bus_err_e err_q;

// =========================================================================
// Handshake
// =========================================================================

// The access issues once the merger can take it this cycle
assign fire = iss_q & acc_ready_i;

// Only one access lives in the decoder
// A new one may enter on the same edge that the current one issues
assign req_ready_o = ~pend_q & (~iss_q | fire);
assign accept = req_valid_i & req_ready_o;

always_ff @(posedge clk_i)
begin
	if (reset_i)
	begin
		pend_q <= 1'b0;
		iss_q <= 1'b0;
	end
	else
	begin
		pend_q <= accept;
		iss_q <= pend_q | (iss_q & ~fire);
	end
end

// Payload capture on the accepting edge
always_ff @(posedge clk_i)
begin
	if (accept)
	begin
		we_q <= req_we_i;
		adr_q <= req_adr_i;
		dat_q <= req_dat_i;
		tid_q <= req_tid_i;
	end
end

// =========================================================================
// Address decode
// =========================================================================

always_comb
begin
	hit = adr_q[`REGION_LSB +: 4] == `CFG_REGION;
	chan_d = adr_q[`CHAN_LSB +: `PIT_CHAN_BITS];
	sel_d = '0;
	// Outside the region no channel is selected at all
	if (hit)
		sel_d[chan_d] = 1'b1;
end

// The decode stage registers its results one cycle after acceptance
always_ff @(posedge clk_i)
begin
	if (pend_q)
	begin
		sel_q <= sel_d;
		ofs_q <= pit_reg_e'(adr_q[`REG_LSB +: 2]);
		chan_q <= chan_d;
		err_q <= hit ? OKAY : DECERR;
	end
end

// =========================================================================
// Strobes and access record
// =========================================================================

// Channel select and write enable are high only in the issue cycle
assign chan_sel_o = fire ? sel_q : '0;
assign reg_we_o = fire & we_q;
assign reg_ofs_o = ofs_q;
assign reg_wdata_o = dat_q;

assign acc_valid_o = iss_q;
assign acc_chan_o = chan_q;
assign acc_tid_o = tid_q;
assign acc_err_o = err_q;

endmodule

//--- pit_channel.sv
// Interval timer channel

`timescale 1ns/100ps

module pit_channel
(
	input  logic clk_i,
	input  logic reset_i,
	input  logic sel_i,
	input  logic we_i,
	input  pit_pkg::pit_reg_e ofs_i,
	input  pit_pkg::pit_wdata_u wdata_i,
	output fta_bus_pkg::data_t rdata_o,
	input  logic tmr_clk_i,
	input  logic tmr_gate_i,
	output logic tmr_out_o,
	output logic irq_o
);

import pit_pkg::*;

// Programmable state
pit_ctrl_t ctrl_q;
pit_count_t reload_q;
pit_count_t count_q;
logic pend_q;
logic out_q;

// Count clock and gate after synchronizing to clk_i
logic [2:0] tclk_sync_q;
logic [1:0] gate_sync_q;
logic tclk_rise;
logic tick;
logic wr;
logic clr_pend;
logic set_pend;

// =========================================================================
// Count clock synchronizer and edge detect
// =========================================================================

// Two flops resolve metastability, the third keeps the previous level
always_ff @(posedge clk_i)
begin
	if (reset_i)
	begin
		tclk_sync_q <= '0;
		gate_sync_q <= '0;
	end
	else
	begin
		tclk_sync_q <= {tclk_sync_q[1:0], tmr_clk_i};
		gate_sync_q <= {gate_sync_q[0], tmr_gate_i};
	end
end

assign tclk_rise = tclk_sync_q[1] & ~tclk_sync_q[2];

// A count step needs an enabled channel, an open gate and a nonzero count
assign tick = tclk_rise & ctrl_q.enable & gate_sync_q[1] & (count_q != '0);

assign wr = sel_i & we_i;
assign clr_pend = wr & (ofs_i == REG_STATUS) & wdata_i.rld.value[0];
assign set_pend = tick & (count_q == pit_count_t'(1));

// =========================================================================
// Registers and down-counter
// =========================================================================

always_ff @(posedge clk_i)
begin
	if (reset_i)
	begin
		ctrl_q <= '0;
		reload_q <= '0;
		count_q <= '0;
		out_q <= 1'b0;
		pend_q <= 1'b0;
	end
	else
	begin
		if (tick)
		begin
			if (count_q == pit_count_t'(1))
			begin
				// Terminal count
				if (ctrl_q.mode == MODE_PERIODIC)
				begin
					count_q <= reload_q;
					out_q <= ~out_q;
				end
				else
				begin
					count_q <= '0;
					out_q <= 1'b1;
				end
			end
			else
				count_q <= count_q - pit_count_t'(1);
		end
		// A register write wins over a count step in the same cycle
		if (wr)
		begin
			case (ofs_i)
			REG_CTRL:
				ctrl_q <= wdata_i.ctrl;
			REG_RELOAD:
				begin
					reload_q <= wdata_i.rld.value;
					count_q <= wdata_i.rld.value;
					out_q <= 1'b0;
				end
			REG_COUNT:
				count_q <= wdata_i.rld.value;
			default:
				;
			endcase
		end
		// A new terminal count is not lost to a clear in the same cycle
		pend_q <= (pend_q & ~clr_pend) | set_pend;
	end
end

// =========================================================================
// Read port and pins
// =========================================================================

// Read data is zero while a write is presented, so writes return no data
always_comb
begin
	rdata_o = '0;
	if (!we_i)
	begin
		case (ofs_i)
		REG_CTRL:   rdata_o = ctrl_q;
		REG_RELOAD: rdata_o = {32'd0, reload_q};
		REG_COUNT:  rdata_o = {32'd0, count_q};
		REG_STATUS: rdata_o = {62'd0, out_q, pend_q};
		endcase
	end
end

assign tmr_out_o = out_q;
assign irq_o = pend_q & ctrl_q.irq_en;

endmodule

//--- pit_resp_merge.sv
// Timer response merger

`timescale 1ns/100ps
`include "mpu_consts.svh"

module pit_resp_merge
(
	input  logic clk_i,
	input  logic reset_i,
	input  logic acc_valid_i,
	output logic acc_ready_o,
	input  logic [`PIT_CHAN_BITS-1:0] acc_chan_i,
	input  fta_bus_pkg::tid_t acc_tid_i,
	input  fta_bus_pkg::bus_err_e acc_err_i,
	input  fta_bus_pkg::data_t [`PIT_CHANNELS-1:0] chan_rdata_i,
	output logic resp_valid_o,
	input  logic resp_ready_i,
	output fta_bus_pkg::data_t resp_dat_o,
	output fta_bus_pkg::tid_t resp_tid_o,
	output fta_bus_pkg::bus_err_e resp_err_o
);

import fta_bus_pkg::*;

logic capture;
data_t rd_word;

// =========================================================================
// Response slot control
// =========================================================================

// The single slot can refill on the edge that drains it
assign acc_ready_o = ~resp_valid_o | resp_ready_i;
assign capture = acc_valid_i & acc_ready_o;

always_ff @(posedge clk_i)
begin
	if (reset_i)
		resp_valid_o <= 1'b0;
	else if (capture)
		resp_valid_o <= 1'b1;
	else if (resp_ready_i)
		resp_valid_o <= 1'b0;
end

// =========================================================================
// Data select and capture
// =========================================================================

// Pick the addressed channel's read word
// Channels already give zero on writes, so only a decode error is masked here
always_comb
begin
	rd_word = chan_rdata_i[acc_chan_i];
	if (acc_err_i != OKAY)
		rd_word = '0;
end

// Payload is held unchanged while the master stalls the response
always_ff @(posedge clk_i)
begin
	if (capture)
	begin
		resp_dat_o <= rd_word;
		resp_tid_o <= acc_tid_i;
		resp_err_o <= acc_err_i;
	end
end

endmodule

//--- mpu_timer_unit.sv
// Timer unit top level

`timescale 1ns/100ps
`include "mpu_consts.svh"

module mpu_timer_unit
(
	input  logic clk_i,
	input  logic reset_i,
	// Request side
	input  logic req_valid_i,
	output logic req_ready_o,
	input  logic req_we_i,
	input  logic [31:0] req_adr_i,
	input  fta_bus_pkg::data_t req_dat_i,
	input  fta_bus_pkg::tid_t req_tid_i,
	// Response side
	output logic resp_valid_o,
	input  logic resp_ready_i,
	output fta_bus_pkg::data_t resp_dat_o,
	output fta_bus_pkg::tid_t resp_tid_o,
	output fta_bus_pkg::bus_err_e resp_err_o,
	// Timer pins, one bit per channel
	input  logic [`PIT_CHANNELS-1:0] tmr_clk_i,
	input  logic [`PIT_CHANNELS-1:0] tmr_gate_i,
	output logic [`PIT_CHANNELS-1:0] tmr_out_o,
	output logic [`PIT_CHANNELS-1:0] irq_o
);

import fta_bus_pkg::*;
import pit_pkg::*;

// Register strobes shared by all channels
logic [`PIT_CHANNELS-1:0] chan_sel;
logic reg_we;
pit_reg_e reg_ofs;
pit_wdata_u reg_wdata;

// Access record passed to the merger
logic acc_valid;
logic acc_ready;
logic [`PIT_CHAN_BITS-1:0] acc_chan;
tid_t acc_tid;
bus_err_e acc_err;

data_t [`PIT_CHANNELS-1:0] chan_rdata;

// =========================================================================
// Request decode
// =========================================================================

pit_reg_decoder pit_reg_decoder_inst
(
	.clk_i(clk_i),
	.reset_i(reset_i),
	.req_valid_i(req_valid_i),
	.req_ready_o(req_ready_o),
	.req_we_i(req_we_i),
	.req_adr_i(req_adr_i),
	.req_dat_i(req_dat_i),
	.req_tid_i(req_tid_i),
	.chan_sel_o(chan_sel),
	.reg_we_o(reg_we),
	.reg_ofs_o(reg_ofs),
	.reg_wdata_o(reg_wdata),
	.acc_valid_o(acc_valid),
	.acc_chan_o(acc_chan),
	.acc_tid_o(acc_tid),
	.acc_err_o(acc_err),
	.acc_ready_i(acc_ready)
);

// =========================================================================
// Timer channels
// =========================================================================

for (genvar i = 0; i < `PIT_CHANNELS; i++)
begin : g_chan
	pit_channel pit_channel_inst
	(
		.clk_i(clk_i),
		.reset_i(reset_i),
		.sel_i(chan_sel[i]),
		.we_i(reg_we),
		.ofs_i(reg_ofs),
		.wdata_i(reg_wdata),
		.rdata_o(chan_rdata[i]),
		.tmr_clk_i(tmr_clk_i[i]),
		.tmr_gate_i(tmr_gate_i[i]),
		.tmr_out_o(tmr_out_o[i]),
		.irq_o(irq_o[i])
	);
end

// =========================================================================
// Response path
// =========================================================================

pit_resp_merge pit_resp_merge_inst
(
	.clk_i(clk_i),
	.reset_i(reset_i),
	.acc_valid_i(acc_valid),
	.acc_ready_o(acc_ready),
	.acc_chan_i(acc_chan),
	.acc_tid_i(acc_tid),
	.acc_err_i(acc_err),
	.chan_rdata_i(chan_rdata),
	.resp_valid_o(resp_valid_o),
	.resp_ready_i(resp_ready_i),
	.resp_dat_o(resp_dat_o),
	.resp_tid_o(resp_tid_o),
	.resp_err_o(resp_err_o)
);

endmodule

//--- tb_mpu_timer_unit.sv
// Timer unit testbench

`timescale 1ns/100ps
`include "mpu_consts.svh"

module tb_mpu_timer_unit;

import fta_bus_pkg::*;
import pit_pkg::*;

// Longest wait on any handshake or poll, in clock cycles or bus reads
localparam int TIMEOUT = 200;

logic clk_i;
logic reset_i;
logic req_valid_i;
logic req_ready_o;
logic req_we_i;
logic [31:0] req_adr_i;
data_t req_dat_i;
tid_t req_tid_i;
logic resp_valid_o;
logic resp_ready_i;
data_t resp_dat_o;
tid_t resp_tid_o;
bus_err_e resp_err_o;
logic [`PIT_CHANNELS-1:0] tmr_clk_i;
logic [`PIT_CHANNELS-1:0] tmr_gate_i;
logic [`PIT_CHANNELS-1:0] tmr_out_o;
logic [`PIT_CHANNELS-1:0] irq_o;

// Error and test counters
int errors;
int tests_run;
int tests_bad;

// Reload value last written to each channel
data_t reload_shadow [`PIT_CHANNELS];

mpu_timer_unit mpu_timer_unit_inst
(
	.clk_i(clk_i),
	.reset_i(reset_i),
	.req_valid_i(req_valid_i),
	.req_ready_o(req_ready_o),
	.req_we_i(req_we_i),
	.req_adr_i(req_adr_i),
	.req_dat_i(req_dat_i),
	.req_tid_i(req_tid_i),
	.resp_valid_o(resp_valid_o),
	.resp_ready_i(resp_ready_i),
	.resp_dat_o(resp_dat_o),
	.resp_tid_o(resp_tid_o),
	.resp_err_o(resp_err_o),
	.tmr_clk_i(tmr_clk_i),
	.tmr_gate_i(tmr_gate_i),
	.tmr_out_o(tmr_out_o),
	.irq_o(irq_o)
);

// 40 ns system clock
initial
begin
	clk_i = 1'b0;
	forever
		#20 clk_i = ~clk_i;
end

// ==========================================================================
// Checking helpers
// ==========================================================================

task automatic compare(string name, logic [63:0] exp, logic [63:0] act);
	if (exp !== act)
	begin
		$display("ERR %s: expected %h, got %h", name, exp, act);
		errors++;
	end
endtask

task automatic report_fault(string what);
	$display("Fault: %s", what);
	errors++;
endtask

// One line per finished test, errors counted since the test started
task automatic finish_test(string name, int errs_before);
	tests_run++;
	if (errors == errs_before)
		$display("[%s] ok", name);
	else
	begin
		tests_bad++;
		$display("[%s] %0d errors", name, errors - errs_before);
	end
endtask

// Register address: region in bits 31..28, channel in 6..5, register in 4..3
function automatic logic [31:0] reg_adr(int ch, pit_reg_e ofs);
	logic [31:0] adr;
	adr = '0;
	adr[`REGION_LSB +: 4] = `CFG_REGION;
	adr[`CHAN_LSB +: 2] = 2'(ch);
	adr[`REG_LSB +: 2] = ofs;
	return adr;
endfunction

function automatic data_t ctrl_word(logic enable, pit_mode_e mode, logic irq_en);
	pit_ctrl_t c;
	c = '0;
	c.enable = enable;
	c.mode = mode;
	c.irq_en = irq_en;
	return c;
endfunction

function automatic logic [`PIT_CHANNELS-1:0] chan_bit(int ch);
	logic [`PIT_CHANNELS-1:0] b;
	b = '0;
	b[ch] = 1'b1;
	return b;
endfunction

// ==========================================================================
// Bus tasks
// ==========================================================================

// Holds the request until the decoder takes it, then drops valid
task automatic send_req(logic we, logic [31:0] adr, data_t dat, tid_t tid);
	int waited;
	waited = 0;
	@(negedge clk_i);
	req_valid_i = 1'b1;
	req_we_i = we;
	req_adr_i = adr;
	req_dat_i = dat;
	req_tid_i = tid;
	#1;
	while (!req_ready_o && waited < TIMEOUT)
	begin
		@(negedge clk_i);
		#1;
		waited++;
	end
	if (!req_ready_o)
		report_fault("request was not accepted before the timeout");
	@(posedge clk_i);
	@(negedge clk_i);
	req_valid_i = 1'b0;
endtask

// Opens resp_ready_i for exactly one response
task automatic recv_resp(output data_t dat, output tid_t tid, output bus_err_e err);
	int waited;
	waited = 0;
	@(negedge clk_i);
	resp_ready_i = 1'b1;
	#1;
	while (!resp_valid_o && waited < TIMEOUT)
	begin
		@(negedge clk_i);
		#1;
		waited++;
	end
	if (!resp_valid_o)
		report_fault("no response arrived before the timeout");
	dat = resp_dat_o;
	tid = resp_tid_o;
	err = resp_err_o;
	@(posedge clk_i);
	@(negedge clk_i);
	resp_ready_i = 1'b0;
endtask

// Writes return zero data with the tag echoed and OKAY status
task automatic bus_write(int ch, pit_reg_e ofs, data_t dat);
	tid_t tid;
	data_t rdat;
	tid_t rtid;
	bus_err_e rerr;
	tid = tid_t'($urandom);
	send_req(1'b1, reg_adr(ch, ofs), dat, tid);
	recv_resp(rdat, rtid, rerr);
	compare("resp_tid_o", 64'(tid), 64'(rtid));
	compare("resp_err_o", 64'(OKAY), 64'(rerr));
	compare("resp_dat_o", 64'(0), rdat);
endtask

task automatic bus_read(int ch, pit_reg_e ofs, output data_t dat);
	tid_t tid;
	tid_t rtid;
	bus_err_e rerr;
	tid = tid_t'($urandom);
	send_req(1'b0, reg_adr(ch, ofs), 64'(0), tid);
	recv_resp(dat, rtid, rerr);
	compare("resp_tid_o", 64'(tid), 64'(rtid));
	compare("resp_err_o", 64'(OKAY), 64'(rerr));
endtask

// Polls the count register, each poll is one bus read
task automatic wait_count(int ch, data_t exp);
	data_t cnt;
	int tries;
	tries = 0;
	bus_read(ch, REG_COUNT, cnt);
	while (cnt != exp && tries < TIMEOUT)
	begin
		bus_read(ch, REG_COUNT, cnt);
		tries++;
	end
	compare("resp_dat_o", exp, cnt);
endtask

// Each pulse is five clocks high and five low, wider than the synchronizer
task automatic pulse_tmr_clk(int ch, int n);
	for (int i = 0; i < n; i++)
	begin
		@(negedge clk_i);
		tmr_clk_i[ch] = 1'b1;
		repeat (5) @(negedge clk_i);
		tmr_clk_i[ch] = 1'b0;
		repeat (4) @(negedge clk_i);
	end
endtask

// ==========================================================================
// Tests
// ==========================================================================

task automatic test_reset_state();
	int start;
	data_t d;
	start = errors;
	@(negedge clk_i);
	#1;
	compare("req_ready_o", 64'(1), 64'(req_ready_o));
	compare("resp_valid_o", 64'(0), 64'(resp_valid_o));
	compare("tmr_out_o", 64'(0), 64'(tmr_out_o));
	compare("irq_o", 64'(0), 64'(irq_o));
	for (int ch = 0; ch < `PIT_CHANNELS; ch++)
	begin
		bus_read(ch, REG_COUNT, d);
		compare("resp_dat_o", 64'(0), d);
	end
	finish_test("reset_state", start);
endtask

// Gates stay low here, so a random enable cannot start a count
task automatic test_register_access();
	int start;
	data_t ctrl;
	data_t rld;
	data_t d;
	start = errors;
	for (int ch = 0; ch < `PIT_CHANNELS; ch++)
	begin
		ctrl = {$urandom, $urandom};
		rld = {32'd0, $urandom};
		reload_shadow[ch] = rld;
		bus_write(ch, REG_CTRL, ctrl);
		bus_write(ch, REG_RELOAD, rld);
		bus_read(ch, REG_CTRL, d);
		compare("resp_dat_o", ctrl, d);
		bus_read(ch, REG_RELOAD, d);
		compare("resp_dat_o", rld, d);
		bus_read(ch, REG_COUNT, d);
		compare("resp_dat_o", rld, d);
	end
	finish_test("register_access", start);
endtask

task automatic test_decode_error();
	int start;
	logic [31:0] adr;
	tid_t tid;
	data_t rdat;
	tid_t rtid;
	bus_err_e rerr;
	start = errors;
	// Channel 0 reload register, but in region 5
	adr = reg_adr(0, REG_RELOAD);
	adr[`REGION_LSB +: 4] = 4'h5;
	tid = tid_t'($urandom);
	send_req(1'b1, adr, ~reload_shadow[0], tid);
	recv_resp(rdat, rtid, rerr);
	compare("resp_tid_o", 64'(tid), 64'(rtid));
	compare("resp_err_o", 64'(DECERR), 64'(rerr));
	compare("resp_dat_o", 64'(0), rdat);
	tid = tid + 8'd1;
	send_req(1'b0, adr, 64'(0), tid);
	recv_resp(rdat, rtid, rerr);
	compare("resp_tid_o", 64'(tid), 64'(rtid));
	compare("resp_err_o", 64'(DECERR), 64'(rerr));
	compare("resp_dat_o", 64'(0), rdat);
	// The stray write must not have reached the channel
	bus_read(0, REG_RELOAD, rdat);
	compare("resp_dat_o", reload_shadow[0], rdat);
	bus_read(0, REG_COUNT, rdat);
	compare("resp_dat_o", reload_shadow[0], rdat);
	finish_test("decode_error", start);
endtask

task automatic test_oneshot();
	int start;
	int ch;
	int n;
	data_t d;
	start = errors;
	ch = int'($urandom % 32'd4);
	n = 2 + int'($urandom % 32'd8);
	bus_write(ch, REG_CTRL, ctrl_word(1'b1, MODE_ONESHOT, 1'b1));
	bus_write(ch, REG_RELOAD, 64'(n));
	reload_shadow[ch] = 64'(n);
	// Gate closed, so the pulses are ignored
	pulse_tmr_clk(ch, n);
	bus_read(ch, REG_COUNT, d);
	compare("resp_dat_o", 64'(n), d);
	@(negedge clk_i);
	tmr_gate_i[ch] = 1'b1;
	pulse_tmr_clk(ch, n);
	wait_count(ch, 64'(0));
	@(negedge clk_i);
	#1;
	compare("tmr_out_o", 64'(chan_bit(ch)), 64'(tmr_out_o));
	compare("irq_o", 64'(chan_bit(ch)), 64'(irq_o));
	// Status holds the output level in bit 1 and the pending flag in bit 0
	bus_read(ch, REG_STATUS, d);
	compare("resp_dat_o", 64'(3), d);
	bus_write(ch, REG_STATUS, 64'(1));
	@(negedge clk_i);
	#1;
	compare("irq_o", 64'(0), 64'(irq_o));
	compare("tmr_out_o", 64'(chan_bit(ch)), 64'(tmr_out_o));
	tmr_gate_i[ch] = 1'b0;
	finish_test("oneshot", start);
endtask

task automatic test_periodic();
	int start;
	int ch;
	int n;
	data_t d;
	start = errors;
	ch = int'($urandom % 32'd4);
	n = 2 + int'($urandom % 32'd8);
	bus_write(ch, REG_CTRL, ctrl_word(1'b1, MODE_PERIODIC, 1'b0));
	bus_write(ch, REG_RELOAD, 64'(n));
	bus_write(ch, REG_STATUS, 64'(1));
	reload_shadow[ch] = 64'(n);
	@(negedge clk_i);
	tmr_gate_i[ch] = 1'b1;
	// Two full periods, the output toggles at the end of each
	for (int p = 0; p < 2; p++)
	begin
		pulse_tmr_clk(ch, n - 1);
		wait_count(ch, 64'(1));
		pulse_tmr_clk(ch, 1);
		wait_count(ch, 64'(n));
		#1;
		compare("tmr_out_o", 64'(p == 0), 64'(tmr_out_o[ch]));
		compare("irq_o", 64'(0), 64'(irq_o[ch]));
	end
	bus_read(ch, REG_STATUS, d);
	compare("resp_dat_o", 64'(1), d);
	tmr_gate_i[ch] = 1'b0;
	finish_test("periodic", start);
endtask

task automatic test_backpressure();
	int start;
	int waited;
	tid_t tid_a;
	tid_t tid_b;
	data_t rdat;
	tid_t rtid;
	bus_err_e rerr;
	start = errors;
	tid_a = tid_t'($urandom);
	tid_b = tid_a ^ 8'h5a;
	// resp_ready_i is low between responses, so both reads stay queued
	send_req(1'b0, reg_adr(0, REG_RELOAD), 64'(0), tid_a);
	send_req(1'b0, reg_adr(1, REG_RELOAD), 64'(0), tid_b);
	waited = 0;
	@(negedge clk_i);
	#1;
	while (req_ready_o && waited < TIMEOUT)
	begin
		@(negedge clk_i);
		#1;
		waited++;
	end
	if (req_ready_o)
		report_fault("req_ready_o stayed high with the response stalled");
	compare("resp_valid_o", 64'(1), 64'(resp_valid_o));
	compare("resp_tid_o", 64'(tid_a), 64'(resp_tid_o));
	recv_resp(rdat, rtid, rerr);
	compare("resp_tid_o", 64'(tid_a), 64'(rtid));
	compare("resp_err_o", 64'(OKAY), 64'(rerr));
	compare("resp_dat_o", reload_shadow[0], rdat);
	recv_resp(rdat, rtid, rerr);
	compare("resp_tid_o", 64'(tid_b), 64'(rtid));
	compare("resp_err_o", 64'(OKAY), 64'(rerr));
	compare("resp_dat_o", reload_shadow[1], rdat);
	finish_test("backpressure", start);
endtask

// ==========================================================================
// Main sequence
// ==========================================================================

initial
begin
	void'($urandom(32'hba1d6ed3));
	errors = 0;
	tests_run = 0;
	tests_bad = 0;
	reset_i = 1'b1;
	req_valid_i = 1'b0;
	req_we_i = 1'b0;
	req_adr_i = '0;
	req_dat_i = '0;
	req_tid_i = '0;
	resp_ready_i = 1'b0;
	tmr_clk_i = '0;
	tmr_gate_i = '0;
	repeat (5) @(posedge clk_i);
	@(negedge clk_i);
	reset_i = 1'b0;

	test_reset_state();
	test_register_access();
	test_decode_error();
	test_oneshot();
	test_periodic();
	test_backpressure();

	$display("Summary: %0d tests run, %0d clean, %0d with errors, %0d errors in all",
		tests_run, tests_run - tests_bad, tests_bad, errors);
	if (errors == 0)
		$display("all tests passed");
	else
		$display("tests failed");
	$finish;
end

endmodule

//--- all.f
+incdir+.
fta_bus_pkg.sv
pit_pkg.sv
pit_reg_decoder.sv
pit_channel.sv
pit_resp_merge.sv
mpu_timer_unit.sv
tb_mpu_timer_unit.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_mpu_timer_unit
FILELIST = all.f

BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(TOOL), run $(TOP) and check $(LOG)"
	@echo "  clean  remove the build folder and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation result: PASS"; \
	else \
		echo "Simulation result: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
